//--- flist.f
id_ser_pkg.sv
ar_dispatch.sv
id_lane.sv
r_return.sv
ar_spill_reg.sv
id_serialize_top.sv
id_serialize_properties.sv
tb_id_serialize.sv

//--- tb_id_serialize.sv
////////////////////
// Testbench for the AXI read ID serializer
// Request table, responder model, scoreboard and watchdog
////////////////////
`timescale 1ns/1ns

module tb_id_serialize;

  // Request entry with slave ID, address, len and the lane it must land on
  typedef struct packed {
    logic [id_ser_pkg::SLV_ID_W-1:0] id;
    logic [id_ser_pkg::ADDR_W-1:0]   addr;
    logic [id_ser_pkg::LEN_W-1:0]    len;
    logic [id_ser_pkg::MST_ID_W-1:0] lane;
  } req_t;

  localparam int NUM_REQ = 16;
  localparam int MAX_LEN = 3;
  localparam int RESET_CYCLES = 10;
  localparam int WATCHDOG_CYCLES = NUM_REQ * (MAX_LEN + 1) * 20 + RESET_CYCLES;

  // Lane column is (id + 1) mod 4
  // 3, 7, 15 and 11 all collide on lane 0
  localparam req_t REQ_TBL [NUM_REQ] = '{
    '{4'd3,  16'h0100, 8'd2, 2'd0}, '{4'd7,  16'h0200, 8'd1, 2'd0},
    '{4'd0,  16'h0300, 8'd3, 2'd1}, '{4'd5,  16'h0400, 8'd0, 2'd2},
    '{4'd3,  16'h0500, 8'd1, 2'd0}, '{4'd15, 16'h0600, 8'd3, 2'd0},
    '{4'd2,  16'h0700, 8'd2, 2'd3}, '{4'd4,  16'h0800, 8'd0, 2'd1},
    '{4'd9,  16'h0900, 8'd1, 2'd2}, '{4'd14, 16'h0A00, 8'd3, 2'd3},
    '{4'd11, 16'h0B00, 8'd0, 2'd0}, '{4'd6,  16'h0C00, 8'd2, 2'd3},
    '{4'd1,  16'h0D00, 8'd1, 2'd2}, '{4'd8,  16'h0E00, 8'd2, 2'd1},
    '{4'd12, 16'h0F00, 8'd3, 2'd1}, '{4'd10, 16'h1000, 8'd0, 2'd3}
  };

  logic clk_i;
  logic rst_n_i;
  id_ser_pkg::slv_ar_t slv_ar_i;
  logic slv_ar_valid_i;
  logic slv_ar_ready_o;
  id_ser_pkg::slv_r_t slv_r_o;
  logic slv_r_valid_o;
  logic slv_r_ready_i;
  id_ser_pkg::mst_ar_t mst_ar_o;
  logic mst_ar_valid_o;
  logic mst_ar_ready_i;
  id_ser_pkg::mst_r_t mst_r_i;
  logic mst_r_valid_i;
  logic mst_r_ready_o;

  // Scoreboard state
  id_ser_pkg::mst_ar_t exp_ar_q [$];  // master ARs in acceptance order
  req_t out_q [$];                    // reads open at the slave side in issue order
  id_ser_pkg::mst_ar_t rsp_q [$];     // master ARs still owed R beats
  int slv_beat [16];
  int rsp_beat [4];
  int last_cnt [4];
  int done_cnt;
  int err_cnt;
  int seed;
  logic [id_ser_pkg::MST_ID_W-1:0] drv_lane;
  logic stall_en;
  logic r_en;

  id_serialize_top id_serialize_top_inst (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .slv_ar_i       (slv_ar_i),
    .slv_ar_valid_i (slv_ar_valid_i),
    .slv_ar_ready_o (slv_ar_ready_o),
    .slv_r_o        (slv_r_o),
    .slv_r_valid_o  (slv_r_valid_o),
    .slv_r_ready_i  (slv_r_ready_i),
    .mst_ar_o       (mst_ar_o),
    .mst_ar_valid_o (mst_ar_valid_o),
    .mst_ar_ready_i (mst_ar_ready_i),
    .mst_r_i        (mst_r_i),
    .mst_r_valid_i  (mst_r_valid_i),
    .mst_r_ready_o  (mst_r_ready_o)
  );

  bind id_serialize_top id_serialize_properties id_serialize_properties_inst (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic fail_check(input string msg);
    err_cnt++;
    $display("[FAIL] %0t ns: %s", $time, msg);
    $display("RESULT: FAIL");
    $fatal(1, "Stopped at first mismatch");
  endtask

  // Oldest open read with this slave ID
  function automatic int find_by_id(input logic [3:0] id);
    for (int k = 0; k < out_q.size(); k++) begin
      if (out_q[k].id == id) return k;
    end
    return -1;
  endfunction

  // Oldest open read on this lane
  function automatic int find_by_lane(input logic [1:0] lane);
    for (int k = 0; k < out_q.size(); k++) begin
      if (out_q[k].lane == lane) return k;
    end
    return -1;
  endfunction

  // Oldest master AR waiting for data on this ID
  function automatic int find_pending(input logic [1:0] lane);
    for (int k = 0; k < rsp_q.size(); k++) begin
      if (rsp_q[k].id == lane) return k;
    end
    return -1;
  endfunction

  // Holds valid and payload until the slave AR transfers
  task automatic send_ar(input req_t req);
    slv_ar_i.id   = req.id;
    slv_ar_i.addr = req.addr;
    slv_ar_i.len  = req.len;
    drv_lane = req.lane;
    slv_ar_valid_i = 1'b1;
    do begin
      @(posedge clk_i);
    end while (!slv_ar_ready_o);
    #1;
    slv_ar_valid_i = 1'b0;
  endtask

  // Polls mid-cycle so the scoreboard and responder have settled
  task automatic wait_done(input int target);
    do begin
      @(negedge clk_i);
    end while (done_cnt < target);
    @(posedge clk_i);
    #1;
  endtask

  // Scoreboard samples every handshake on the rising edge
  always @(posedge clk_i) begin : monitor
    int idx;
    int beat;
    req_t ent;
    id_ser_pkg::mst_ar_t exp_ar;
    if (rst_n_i) begin
      // R valid and ready cross the serializer in the same cycle
      assert (slv_r_valid_o == mst_r_valid_i && mst_r_ready_o == slv_r_ready_i)
        else fail_check($sformatf("R valid %0b/%0b or ready %0b/%0b not passed through",
          slv_r_valid_o, mst_r_valid_i, mst_r_ready_o, slv_r_ready_i));
      if (slv_ar_valid_i && slv_ar_ready_o) begin
        exp_ar.id   = drv_lane;
        exp_ar.addr = slv_ar_i.addr;
        exp_ar.len  = slv_ar_i.len;
        exp_ar_q.push_back(exp_ar);
        out_q.push_back('{slv_ar_i.id, slv_ar_i.addr, slv_ar_i.len, drv_lane});
      end
      if (mst_ar_valid_o && mst_ar_ready_i) begin
        assert (exp_ar_q.size() > 0) else fail_check("master AR appeared with no slave AR");
        assert (mst_ar_o == exp_ar_q[0])
          else fail_check($sformatf("master AR id %0d addr %h len %0d, expected %0d %h %0d",
            mst_ar_o.id, mst_ar_o.addr, mst_ar_o.len,
            exp_ar_q[0].id, exp_ar_q[0].addr, exp_ar_q[0].len));
        exp_ar_q.pop_front();
        rsp_q.push_back(mst_ar_o);
      end
      if (mst_r_valid_i && mst_r_ready_o && mst_r_i.last) begin
        last_cnt[mst_r_i.id]++;
      end
      if (slv_r_valid_o && slv_r_ready_i) begin
        idx = find_by_id(slv_r_o.id);
        assert (idx >= 0)
          else fail_check($sformatf("R beat for slave ID %0d with no open read", slv_r_o.id));
        ent = out_q[idx];
        beat = slv_beat[slv_r_o.id];
        // Same-lane reads must finish in issue order
        assert (find_by_lane(ent.lane) == idx)
          else fail_check($sformatf("slave ID %0d overtook an older read on lane %0d",
            slv_r_o.id, ent.lane));
        assert (slv_r_o.data == 32'(ent.addr) + 32'(beat))
          else fail_check($sformatf("ID %0d beat %0d data %h, expected %h", slv_r_o.id,
            beat, slv_r_o.data, 32'(ent.addr) + 32'(beat)));
        assert (slv_r_o.resp == id_ser_pkg::RESP_OKAY)
          else fail_check($sformatf("ID %0d resp %0d, expected OKAY", slv_r_o.id, slv_r_o.resp));
        assert (slv_r_o.last == (beat == int'(ent.len)))
          else fail_check($sformatf("ID %0d beat %0d last %0b", slv_r_o.id, beat, slv_r_o.last));
        if (slv_r_o.last) begin
          out_q.delete(idx);
          slv_beat[slv_r_o.id] = 0;
          done_cnt++;
        end else begin
          slv_beat[slv_r_o.id]++;
        end
      end
    end
  end

  // Random stalls on both ready inputs
  initial begin : stall_gen
    forever begin
      @(posedge clk_i);
      #1;
      if (stall_en) begin
        mst_ar_ready_i = (($random(seed) & 3) != 0);
        slv_r_ready_i  = (($random(seed) & 3) != 0);
      end
    end
  end

  // Memory model answers in order per master ID and interleaves across IDs
  initial begin : responder
    int start;
    int lane;
    int idx;
    int cur_idx;
    logic xfer;
    cur_idx = -1;
    forever begin
      @(posedge clk_i);
      xfer = mst_r_valid_i && mst_r_ready_o;
      #1;
      if (xfer) begin
        lane = mst_r_i.id;
        if (mst_r_i.last) begin
          rsp_q.delete(cur_idx);
          rsp_beat[lane] = 0;
        end else begin
          rsp_beat[lane]++;
        end
        mst_r_valid_i = 1'b0;
      end
      if (!mst_r_valid_i && r_en && rsp_q.size() > 0) begin
        start = $random(seed) & 3;
        idx = -1;
        for (int k = 0; k < 4 && idx < 0; k++) begin
          lane = (start + k) % 4;
          idx = find_pending(2'(lane));
        end
        if (idx >= 0) begin
          cur_idx = idx;
          mst_r_i.id   = 2'(lane);
          mst_r_i.data = 32'(rsp_q[idx].addr) + 32'(rsp_beat[lane]);
          mst_r_i.resp = id_ser_pkg::RESP_OKAY;
          mst_r_i.last = (rsp_beat[lane] == int'(rsp_q[idx].len));
          mst_r_valid_i = 1'b1;
        end
      end
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("Timeout: the run did not complete within %0d cycles", WATCHDOG_CYCLES);
    $display("RESULT: FAIL");
    $fatal(1, "Watchdog expired");
  end

  initial begin : main
    int acc;
    int base;
    seed = 2;
    err_cnt = 0;
    done_cnt = 0;
    rst_n_i = 1'b0;
    slv_ar_i = '0;
    slv_ar_valid_i = 1'b0;
    slv_r_ready_i = 1'b0;
    mst_ar_ready_i = 1'b0;
    mst_r_i = '0;
    mst_r_valid_i = 1'b0;
    drv_lane = '0;
    stall_en = 1'b0;
    r_en = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    // Idle port state out of reset
    @(posedge clk_i);
    assert (slv_ar_ready_o && !mst_ar_valid_o && !slv_r_valid_o)
      else fail_check("idle state after reset is wrong");
    #1;
    // Table traffic with random stalls
    stall_en = 1'b1;
    r_en = 1'b1;
    for (int i = 0; i < NUM_REQ; i++) begin
      send_ar(REQ_TBL[i]);
    end
    wait_done(NUM_REQ);
    // Spill register takes two ARs while the master AR is blocked
    stall_en = 1'b0;
    mst_ar_ready_i = 1'b0;
    slv_r_ready_i = 1'b1;
    acc = 0;
    repeat (6) begin
      // Slave ID acc + 1 lands on lane acc + 2
      slv_ar_i.id   = 4'(acc + 1);
      slv_ar_i.addr = 16'h2000 + 16'(acc * 16);
      slv_ar_i.len  = 8'd1;
      drv_lane = 2'(acc + 2);
      slv_ar_valid_i = 1'b1;
      @(posedge clk_i);
      if (slv_ar_ready_o) acc++;
      #1;
    end
    assert (acc == 2)
      else fail_check($sformatf("%0d ARs accepted with master AR blocked, expected 2", acc));
    @(posedge clk_i);
    assert (!slv_ar_ready_o) else fail_check("slave AR ready high with spill register full");
    #1;
    mst_ar_ready_i = 1'b1;
    send_ar('{4'd3, 16'h2020, 8'd1, 2'd0});
    wait_done(NUM_REQ + 3);
    // Lane 1 fills up while R is withheld
    r_en = 1'b0;
    send_ar('{4'd0, 16'h3000, 8'd1, 2'd1});
    send_ar('{4'd4, 16'h3010, 8'd1, 2'd1});
    send_ar('{4'd0, 16'h3020, 8'd1, 2'd1});
    send_ar('{4'd4, 16'h3030, 8'd1, 2'd1});
    slv_ar_i.id   = 4'd4;
    slv_ar_i.addr = 16'h3040;
    slv_ar_i.len  = 8'd0;
    drv_lane = 2'd1;
    slv_ar_valid_i = 1'b1;
    repeat (8) begin
      @(posedge clk_i);
      assert (!slv_ar_ready_o) else fail_check("read to a full lane was accepted");
    end
    #1;
    base = last_cnt[1];
    r_en = 1'b1;
    do begin
      @(posedge clk_i);
    end while (!slv_ar_ready_o);
    assert (last_cnt[1] > base)
      else fail_check("full lane took a read before any last beat returned");
    #1;
    slv_ar_valid_i = 1'b0;
    wait_done(NUM_REQ + 8);
    // Nothing may be left open
    assert (exp_ar_q.size() == 0 && out_q.size() == 0 && rsp_q.size() == 0)
      else fail_check("reads left open at the end of the run");
    if (err_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- id_serialize_properties.sv
////////////////////
// Handshake and ID checks on the serializer ports
// Attached to the top level with bind
////////////////////
`timescale 1ns/1ns

module id_serialize_properties (
  input logic                clk_i,
  input logic                rst_n_i,
  input id_ser_pkg::slv_ar_t slv_ar_i,
  input logic                slv_ar_valid_i,
  input logic                slv_ar_ready_o,
  input id_ser_pkg::slv_r_t  slv_r_o,
  input logic                slv_r_valid_o,
  input logic                slv_r_ready_i,
  input id_ser_pkg::mst_ar_t mst_ar_o,
  input logic                mst_ar_valid_o,
  input logic                mst_ar_ready_i,
  input id_ser_pkg::mst_r_t  mst_r_i,
  input logic                mst_r_valid_i,
  input logic                mst_r_ready_o
);

  // Slave AR holds until accepted
  a_slv_ar_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    slv_ar_valid_i && !slv_ar_ready_o |=> slv_ar_valid_i && $stable(slv_ar_i))
    else $error("Slave AR dropped or changed before it was accepted");

  // Master AR holds until accepted
  a_mst_ar_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mst_ar_valid_o && !mst_ar_ready_i |=> mst_ar_valid_o && $stable(mst_ar_o))
    else $error("Master AR dropped or changed before it was accepted");

  // Beats on both R ports hold too
  a_slv_r_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    slv_r_valid_o && !slv_r_ready_i |=> slv_r_valid_o && $stable(slv_r_o))
    else $error("Slave R beat dropped or changed before it was accepted");

  a_mst_r_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mst_r_valid_i && !mst_r_ready_o |=> mst_r_valid_i && $stable(mst_r_i))
    else $error("Master R beat dropped or changed before it was accepted");

  // Narrow ID must name a real lane
  a_mst_id_range: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mst_ar_valid_o |-> (mst_ar_o.id < id_ser_pkg::NUM_LANES))
    else $error("Master AR ID outside the lane range");

  // No slave beat without a master beat behind it
  a_r_source: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(slv_r_valid_o && !mst_r_valid_i))
    else $error("Slave R valid without master R valid");

endmodule

//--- id_serialize_top.sv
////////////////////
// AXI read ID serializer top
// Maps wide slave IDs onto four in-order lanes
////////////////////
`timescale 1ns/1ns

module id_serialize_top (
  input  logic                clk_i,
  input  logic                rst_n_i,
  // Slave AR
  input  id_ser_pkg::slv_ar_t slv_ar_i,
  input  logic                slv_ar_valid_i,
  output logic                slv_ar_ready_o,
  // Slave R
  output id_ser_pkg::slv_r_t  slv_r_o,
  output logic                slv_r_valid_o,
  input  logic                slv_r_ready_i,
  // Master AR
  output id_ser_pkg::mst_ar_t mst_ar_o,
  output logic                mst_ar_valid_o,
  input  logic                mst_ar_ready_i,
  // Master R
  input  id_ser_pkg::mst_r_t  mst_r_i,
  input  logic                mst_r_valid_i,
  output logic                mst_r_ready_o
);

  // AR between dispatch and lanes
  logic [id_ser_pkg::NUM_LANES-1:0] lane_ar_valid;
  logic [id_ser_pkg::NUM_LANES-1:0] lane_ar_ready;
  id_ser_pkg::mst_ar_t [id_ser_pkg::NUM_LANES-1:0] lane_mst_ar;
  logic [id_ser_pkg::NUM_LANES-1:0] lane_mst_ar_valid;

  // Merged AR into the spill register
  id_ser_pkg::mst_ar_t merged_ar;
  logic merged_ar_valid;
  // Spill ready, shared by all lanes
  logic spill_ready;

  // R between lanes and return path
  logic [id_ser_pkg::NUM_LANES-1:0] lane_r_valid;
  logic [id_ser_pkg::NUM_LANES-1:0] lane_r_ready;
  id_ser_pkg::slv_r_t [id_ser_pkg::NUM_LANES-1:0] lane_slv_r;
  logic [id_ser_pkg::NUM_LANES-1:0] lane_slv_r_valid;

  // Steer slave AR to its lane and merge the lane ARs
  ar_dispatch i_ar_dispatch (
    .slv_ar_i            (slv_ar_i),
    .slv_ar_valid_i      (slv_ar_valid_i),
    .slv_ar_ready_o      (slv_ar_ready_o),
    .lane_ar_valid_o     (lane_ar_valid),
    .lane_ar_ready_i     (lane_ar_ready),
    .lane_mst_ar_i       (lane_mst_ar),
    .lane_mst_ar_valid_i (lane_mst_ar_valid),
    .merged_ar_o         (merged_ar),
    .merged_ar_valid_o   (merged_ar_valid)
  );

  // Lane index doubles as its master ID
  for (genvar i = 0; i < id_ser_pkg::NUM_LANES; i++) begin : gen_lanes
    id_lane i_id_lane (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .lane_id_i      (id_ser_pkg::MST_ID_W'(i)),
      .ar_i           (slv_ar_i),
      .ar_valid_i     (lane_ar_valid[i]),
      .ar_ready_o     (lane_ar_ready[i]),
      .mst_ar_o       (lane_mst_ar[i]),
      .mst_ar_valid_o (lane_mst_ar_valid[i]),
      .mst_ar_ready_i (spill_ready),
      .r_i            (mst_r_i),
      .r_valid_i      (lane_r_valid[i]),
      .r_ready_o      (lane_r_ready[i]),
      .r_o            (lane_slv_r[i]),
      .r_valid_o      (lane_slv_r_valid[i]),
      .r_ready_i      (slv_r_ready_i)
    );
  end

  // R beats back to their lane and on to the slave
  r_return i_r_return (
    .mst_r_i            (mst_r_i),
    .mst_r_valid_i      (mst_r_valid_i),
    .mst_r_ready_o      (mst_r_ready_o),
    .lane_r_valid_o     (lane_r_valid),
    .lane_r_ready_i     (lane_r_ready),
    .lane_slv_r_i       (lane_slv_r),
    .lane_slv_r_valid_i (lane_slv_r_valid),
    .slv_r_o            (slv_r_o),
    .slv_r_valid_o      (slv_r_valid_o)
  );

  // Cuts the master ready path
  ar_spill_reg i_ar_spill_reg (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (merged_ar_valid),
    .ready_o (spill_ready),
    .data_i  (merged_ar),
    .valid_o (mst_ar_valid_o),
    .ready_i (mst_ar_ready_i),
    .data_o  (mst_ar_o)
  );

endmodule

//--- ar_spill_reg.sv
////////////////////
// AR spill register
// Two slots, breaks the ready path at the master port
////////////////////
`timescale 1ns/1ns

module ar_spill_reg (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                valid_i,
  output logic                ready_o,
  input  id_ser_pkg::mst_ar_t data_i,
  output logic                valid_o,
  input  logic                ready_i,
  output id_ser_pkg::mst_ar_t data_o
);

  id_ser_pkg::spill_state_e state_q;
  // Head slot always holds the oldest entry
  id_ser_pkg::mst_ar_t head_q;
  // Second entry while full
  id_ser_pkg::mst_ar_t tail_q;
  logic in_xfer;
  logic out_xfer;

  // Ready depends on state only
  assign ready_o = (state_q != id_ser_pkg::SPILL_TWO);
  assign valid_o = (state_q != id_ser_pkg::SPILL_EMPTY);
  assign data_o  = head_q;

  assign in_xfer  = valid_i & ready_o;
  assign out_xfer = valid_o & ready_i;

  // Fill level
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= id_ser_pkg::SPILL_EMPTY;
    end else begin
      case (state_q)
        id_ser_pkg::SPILL_EMPTY: begin
          if (in_xfer) state_q <= id_ser_pkg::SPILL_ONE;
        end
        id_ser_pkg::SPILL_ONE: begin
          // Simultaneous in and out keeps one entry
          if (in_xfer && !out_xfer) state_q <= id_ser_pkg::SPILL_TWO;
          else if (!in_xfer && out_xfer) state_q <= id_ser_pkg::SPILL_EMPTY;
        end
        id_ser_pkg::SPILL_TWO: begin
          if (out_xfer) state_q <= id_ser_pkg::SPILL_ONE;
        end
        default: state_q <= id_ser_pkg::SPILL_EMPTY;
      endcase
    end
  end

  // Payload slots
  always_ff @(posedge clk_i) begin
    // Incoming beat lands in head when it is free or draining
    if (in_xfer && (state_q == id_ser_pkg::SPILL_EMPTY || out_xfer)) begin
      head_q <= data_i;
    end else if (in_xfer) begin
      tail_q <= data_i;
    end else if (out_xfer && state_q == id_ser_pkg::SPILL_TWO) begin
      // Tail moves up once head leaves
      head_q <= tail_q;
    end
  end

endmodule

//--- r_return.sv
////////////////////
// R return path
// Routes master R beats by ID and merges lane results
////////////////////
`timescale 1ns/1ns

module r_return (
  input  id_ser_pkg::mst_r_t                             mst_r_i,
  input  logic                                           mst_r_valid_i,
  output logic                                           mst_r_ready_o,
  output logic               [id_ser_pkg::NUM_LANES-1:0] lane_r_valid_o,
  input  logic               [id_ser_pkg::NUM_LANES-1:0] lane_r_ready_i,
  input  id_ser_pkg::slv_r_t [id_ser_pkg::NUM_LANES-1:0] lane_slv_r_i,
  input  logic               [id_ser_pkg::NUM_LANES-1:0] lane_slv_r_valid_i,
  output id_ser_pkg::slv_r_t                             slv_r_o,
  output logic                                           slv_r_valid_o
);

  // Lane that currently drives the slave R
  logic [id_ser_pkg::MST_ID_W-1:0] merge_sel;

  // Master ID is the lane index
  always_comb begin
    lane_r_valid_o = '0;
    lane_r_valid_o[mst_r_i.id] = mst_r_valid_i;
  end

  // Ready from the addressed lane only
  assign mst_r_ready_o = lane_r_ready_i[mst_r_i.id];

  // One-hot lane valid to index
  always_comb begin
    merge_sel = '0;
    for (int i = 0; i < id_ser_pkg::NUM_LANES; i++) begin
      if (lane_slv_r_valid_i[i]) begin
        merge_sel = id_ser_pkg::MST_ID_W'(i);
      end
    end
  end

  // At most one lane is valid per beat
  assign slv_r_valid_o = |lane_slv_r_valid_i;
  assign slv_r_o       = lane_slv_r_i[merge_sel];

endmodule

//--- id_lane.sv
////////////////////
// Serializing lane
// Tracks in-flight slave IDs and restores them on R
////////////////////
`timescale 1ns/1ns

module id_lane (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  // Master ID owned by this lane
  input  logic [id_ser_pkg::MST_ID_W-1:0] lane_id_i,
  // AR from dispatch
  input  id_ser_pkg::slv_ar_t             ar_i,
  input  logic                            ar_valid_i,
  output logic                            ar_ready_o,
  // AR toward the spill register
  output id_ser_pkg::mst_ar_t             mst_ar_o,
  output logic                            mst_ar_valid_o,
  input  logic                            mst_ar_ready_i,
  // R from the master port
  input  id_ser_pkg::mst_r_t              r_i,
  input  logic                            r_valid_i,
  output logic                            r_ready_o,
  // R toward the slave port
  output id_ser_pkg::slv_r_t              r_o,
  output logic                            r_valid_o,
  input  logic                            r_ready_i
);

  // Slave IDs of outstanding reads in issue order
  logic [id_ser_pkg::SLV_ID_W-1:0] id_fifo [id_ser_pkg::TXNS_PER_LANE];
  // Pointers wrap at the power-of-two depth
  logic [id_ser_pkg::CNT_W-2:0] wr_ptr;
  logic [id_ser_pkg::CNT_W-2:0] rd_ptr;
  logic [id_ser_pkg::CNT_W-1:0] count;
  logic fifo_full;
  logic fifo_empty;
  logic push;
  logic pop;

  assign fifo_full  = (count == id_ser_pkg::CNT_W'(id_ser_pkg::TXNS_PER_LANE));
  assign fifo_empty = (count == '0);

  // Hold AR back while every slot is taken
  assign mst_ar_valid_o = ar_valid_i & ~fifo_full;
  assign ar_ready_o     = mst_ar_ready_i & ~fifo_full;

  // Narrow ID replaces the slave ID
  always_comb begin
    mst_ar_o.id   = lane_id_i;
    mst_ar_o.addr = ar_i.addr;
    mst_ar_o.len  = ar_i.len;
  end

  // Record slave ID when the AR is taken
  assign push = ar_valid_i & ar_ready_o;

  // R handshake passes straight through
  assign r_valid_o = r_valid_i;
  assign r_ready_o = r_ready_i;

  // Oldest outstanding read owns the beat
  always_comb begin
    r_o.id   = id_fifo[rd_ptr];
    r_o.data = r_i.data;
    r_o.resp = r_i.resp;
    r_o.last = r_i.last;
  end

  // Burst done on the last beat
  assign pop = r_valid_i & r_ready_i & r_i.last & ~fifo_empty;

  // Pointers and occupancy
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // ID storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      id_fifo[wr_ptr] <= ar_i.id;
    end
  end

endmodule

//--- ar_dispatch.sv
////////////////////
// AR dispatch
// Picks the lane for each slave AR and merges lane ARs
////////////////////
`timescale 1ns/1ns

module ar_dispatch (
  input  id_ser_pkg::slv_ar_t                             slv_ar_i,
  input  logic                                            slv_ar_valid_i,
  output logic                                            slv_ar_ready_o,
  output logic                [id_ser_pkg::NUM_LANES-1:0] lane_ar_valid_o,
  input  logic                [id_ser_pkg::NUM_LANES-1:0] lane_ar_ready_i,
  input  id_ser_pkg::mst_ar_t [id_ser_pkg::NUM_LANES-1:0] lane_mst_ar_i,
  input  logic                [id_ser_pkg::NUM_LANES-1:0] lane_mst_ar_valid_i,
  output id_ser_pkg::mst_ar_t                             merged_ar_o,
  output logic                                            merged_ar_valid_o
);

  // Lane targeted by the current slave AR
  logic [id_ser_pkg::MST_ID_W-1:0] lane_sel;
  // Lane currently presenting an AR
  logic [id_ser_pkg::MST_ID_W-1:0] merge_sel;

  // Fixed map: (id + offset) mod lane count
  assign lane_sel = id_ser_pkg::MST_ID_W'(
    (32'(slv_ar_i.id) + id_ser_pkg::ID_BASE_OFFSET) % id_ser_pkg::NUM_LANES);

  // Only the selected lane sees valid
  always_comb begin
    lane_ar_valid_o = '0;
    lane_ar_valid_o[lane_sel] = slv_ar_valid_i;
  end

  // Ready comes back from the same lane
  assign slv_ar_ready_o = lane_ar_ready_i[lane_sel];

  // One-hot valid to index
  // Port is in order so at most one lane drives valid
  always_comb begin
    merge_sel = '0;
    for (int i = 0; i < id_ser_pkg::NUM_LANES; i++) begin
      if (lane_mst_ar_valid_i[i]) begin
        merge_sel = id_ser_pkg::MST_ID_W'(i);
      end
    end
  end

  assign merged_ar_valid_o = |lane_mst_ar_valid_i;
  // Payload of the active lane, lane 0 when idle
  assign merged_ar_o = lane_mst_ar_i[merge_sel];

endmodule

//--- id_ser_pkg.sv
////////////////////
// Shared definitions for the AXI read ID serializer
// Widths, lane counts, AR and R channel structs and state enums
////////////////////
package id_ser_pkg;

  // Slave side carries the wide ID, master side the narrow one
  localparam int unsigned SLV_ID_W = 4;
  localparam int unsigned MST_ID_W = 2;

  // One lane per master ID
  localparam int unsigned NUM_LANES = 4;

  // Outstanding reads per lane and the occupancy counter width
  localparam int unsigned TXNS_PER_LANE = 4;
  localparam int unsigned CNT_W = 3;

  localparam int unsigned ADDR_W = 16;
  localparam int unsigned DATA_W = 32;
  // Burst has len + 1 beats
  localparam int unsigned LEN_W = 8;

  // Added to the slave ID before the modulo
  localparam int unsigned ID_BASE_OFFSET = 1;

  // AXI read response codes
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } resp_e;

  // Fill level of the AR spill register
  typedef enum logic [1:0] {
    SPILL_EMPTY = 2'b00,
    SPILL_ONE   = 2'b01,
    SPILL_TWO   = 2'b10
  } spill_state_e;

  // AR beat at the slave port
  typedef struct packed {
    logic [SLV_ID_W-1:0] id;
    logic [ADDR_W-1:0]   addr;
    logic [LEN_W-1:0]    len;
  } slv_ar_t;

  // AR beat at the master port
  typedef struct packed {
    logic [MST_ID_W-1:0] id;
    logic [ADDR_W-1:0]   addr;
    logic [LEN_W-1:0]    len;
  } mst_ar_t;

  // R beat at the slave port
  typedef struct packed {
    logic [SLV_ID_W-1:0] id;
    logic [DATA_W-1:0]   data;
    resp_e               resp;
    logic                last;
  } slv_r_t;

  // R beat at the master port
  typedef struct packed {
    logic [MST_ID_W-1:0] id;
    logic [DATA_W-1:0]   data;
    resp_e               resp;
    logic                last;
  } mst_r_t;

endpackage
